// ==== ps2_control.sv ====
// mouse init FSM with ack timeout and idle watchdog; packs streamed bytes into 24-bit packets
`timescale 1ns/100ps

module ps2_control
    import ps2_mouse_pkg::*;
#(
    parameter int ms_cycles     = 50_000,
    parameter int idle_limit_ms = 20_000
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    output logic        rd_en,
    input  logic        rd_vld,
    input  logic [7:0]  rd_data,
    output logic        wr_en,
    output logic [7:0]  wr_data,
    input  logic        wr_done,
    output logic        pkt_vld,
    output logic [23:0] pkt_data,
    output logic        init_done,
    output ctrl_state_t ctrl_state
);

    localparam int ms_w   = $clog2(ms_cycles + 1);
    localparam int idle_w = $clog2(idle_limit_ms + 1);
    localparam logic [ms_w-1:0]   ms_last   = ms_w'(ms_cycles - 1);
    localparam logic [idle_w-1:0] idle_last = idle_w'(idle_limit_ms - 1);

    ctrl_state_t       state;
    ctrl_state_t       next_state;
    logic              cmd_sent;
    logic [1:0]        byte_cnt;
    logic [ms_w-1:0]   ms_cnt;
    logic              ms_tick;
    logic [idle_w-1:0] idle_cnt;
    logic              idle_expired;
    logic              in_stream;

    assign in_stream    = (state == stream);
    assign ms_tick      = (ms_cnt == ms_last);
    assign idle_expired = ms_tick && (idle_cnt == idle_last);

    always_comb begin
        next_state = state;
        case (state)
            reset_dev: begin
                if (wr_done) begin
                    next_state = wait_ack;
                end
            end
            wait_ack: begin
                // ack then self-test result
                if (byte_cnt == 2'd2) begin
                    next_state = start_stream;
                end else if (ms_tick) begin
                    next_state = reset_dev;
                end
            end
            start_stream: begin
                if (wr_done) begin
                    next_state = wait_ack2;
                end
            end
            wait_ack2: begin
                if (rd_vld && ((rd_data == rsp_ack) || (rd_data == cmd_enable_stream))) begin
                    next_state = stream;
                end else if (ms_tick) begin
                    next_state = reset_dev;
                end
            end
            stream: begin
                if (idle_expired) begin
                    next_state = reset_dev;
                end
            end
            default: begin
                next_state = reset_dev;
            end
        endcase
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state <= reset_dev;
        end else begin
            state <= next_state;
        end
    end

    assign ctrl_state = state;

    // millisecond timebase, restarts on every state change
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            ms_cnt <= '0;
        end else if ((state != next_state) || (in_stream && rd_vld)) begin
            ms_cnt <= '0;
        end else if ((state == wait_ack) || (state == wait_ack2) || in_stream) begin
            ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;
        end else begin
            ms_cnt <= '0;
        end
    end

    // watchdog in ms, any received byte restarts it
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (!in_stream || rd_vld || idle_expired) begin
            idle_cnt <= '0;
        end else if (ms_tick) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // one wr_en pulse per command state visit
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_en    <= 1'b0;
            cmd_sent <= 1'b0;
        end else if ((state == reset_dev) || (state == start_stream)) begin
            wr_en    <= ~cmd_sent;
            cmd_sent <= 1'b1;
        end else begin
            wr_en    <= 1'b0;
            cmd_sent <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        wr_data <= (state == start_stream) ? cmd_enable_stream : cmd_reset;
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rd_en     <= 1'b0;
            init_done <= 1'b0;
        end else begin
            rd_en     <= (state != reset_dev);
            init_done <= in_stream;
        end
    end

    // counts responses in wait_ack and packet bytes in stream
    // cleared elsewhere so stream always starts on byte 0
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= 2'd0;
        end else if ((state != wait_ack) && !in_stream) begin
            byte_cnt <= 2'd0;
        end else if (rd_vld) begin
            byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pkt_vld <= 1'b0;
        end else begin
            pkt_vld <= in_stream && rd_vld && (byte_cnt == 2'd2);
        end
    end

    // byte 0 lands in the low bits
    always_ff @(posedge clk_sys) begin
        if (in_stream && rd_vld) begin
            case (byte_cnt)
                2'd0: pkt_data[7:0]   <= rd_data;
                2'd1: pkt_data[15:8]  <= rd_data;
                2'd2: pkt_data[23:16] <= rd_data;
                default: pkt_data <= pkt_data;
            endcase
        end
    end

endmodule

// ==== ps2_mouse.f ====
ps2_mouse_pkg.sv
ps2_rx.sv
ps2_tx.sv
ps2_control.sv
ps2_mouse_top.sv
ps2_mouse_tb.sv

// ==== ps2_mouse_pkg.sv ====
// shared state types and command/response byte values, imported by the PS/2 mouse host modules
package ps2_mouse_pkg;

    // mouse init and streaming FSM
    typedef enum logic [2:0] {
        reset_dev,
        wait_ack,
        start_stream,
        wait_ack2,
        stream
    } ctrl_state_t;

    // device-to-host frame receiver
    typedef enum logic [1:0] {
        rx_idle,
        rx_shift,
        rx_parity,
        rx_stop
    } rx_state_t;

    // host-to-device command sender
    typedef enum logic [2:0] {
        tx_idle,
        tx_inhibit,
        tx_request,
        tx_shift,
        tx_parity,
        tx_stop,
        tx_ack,
        tx_done
    } tx_state_t;

    // host commands
    localparam logic [7:0] cmd_reset         = 8'hFF;
    localparam logic [7:0] cmd_enable_stream = 8'hF4;

    // device responses
    localparam logic [7:0] rsp_ack    = 8'hFA;
    localparam logic [7:0] rsp_bat_ok = 8'hAA;

endpackage

// ==== ps2_mouse_tb.sv ====
// simulation top that checks the PS/2 mouse host against a behavioral mouse on the bus lines
`timescale 1ns/100ps

module ps2_mouse_tb
    import ps2_mouse_pkg::*;
();

    localparam int ms_cycles      = 2000;
    localparam int idle_limit_ms  = 4;
    localparam int inhibit_cycles = 100;
    localparam int half_period    = 20;
    localparam int quarter        = half_period / 2;
    localparam int bit_cycles     = 2 * half_period;
    localparam int byte_gap       = 60;
    localparam int frame_cycles   = byte_gap + 11 * bit_cycles;
    localparam int num_groups     = 4;
    // twice the frames of all tests plus the watchdog and ack timeout waits
    localparam int max_cycles = 2 * ((16 + 3 * num_groups) * (frame_cycles + inhibit_cycles)
                                     + (idle_limit_ms + 2) * ms_cycles);

    logic        clk_sys = 1'b0;
    logic        rst_n;
    logic        ps2_clk_in;
    logic        ps2_data_in;
    logic        ps2_clk_oe;
    logic        ps2_data_oe;
    logic        pkt_vld;
    logic [23:0] pkt_data;
    logic        init_done;
    ctrl_state_t ctrl_state;

    // device side drivers of the two lines
    logic        dev_clk;
    logic        dev_data;

    int          errors = 0;
    int          cycle_cnt = 0;
    logic        init_allowed = 1'b0;
    logic [31:0] rng_state = 32'he223_da70;
    logic [23:0] pkt_q[$];

    ps2_mouse_top #(
        .ms_cycles      (ms_cycles),
        .idle_limit_ms  (idle_limit_ms),
        .inhibit_cycles (inhibit_cycles)
    ) dut (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ps2_clk_in  (ps2_clk_in),
        .ps2_data_in (ps2_data_in),
        .ps2_clk_oe  (ps2_clk_oe),
        .ps2_data_oe (ps2_data_oe),
        .pkt_vld     (pkt_vld),
        .pkt_data    (pkt_data),
        .init_done   (init_done),
        .ctrl_state  (ctrl_state)
    );

    always #20 clk_sys = ~clk_sys;

    // open-collector line is low if either side pulls it
    always @(posedge clk_sys) begin
        ps2_clk_in  <= dev_clk & ~ps2_clk_oe;
        ps2_data_in <= dev_data & ~ps2_data_oe;
    end

    // packet capture and init_done watch on the falling edge
    always @(negedge clk_sys) begin
        if (pkt_vld) begin
            pkt_q.push_back(pkt_data);
        end
        assert (!init_done || init_allowed) else begin
            errors++;
            $display("init_done is high at %0t without a stream enable acknowledge", $time);
        end
    end

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == max_cycles) begin
            $display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
            $display("errors: %0d", errors);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // device frame is cut short when the host inhibits the clock
    task automatic send_byte(input logic [7:0] b, input logic bad_parity, output logic sent);
        logic [10:0] frame;
        logic        aborted;
        int          c;
        int          k;
        int          ph;
        frame   = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
        sent    = 1'b0;
        aborted = 1'b0;
        for (c = 0; c < frame_cycles && !aborted; c++) begin
            @(posedge clk_sys);
            k  = c - byte_gap;
            ph = k % bit_cycles;
            if (ps2_clk_oe) begin
                aborted = 1'b1;
            end else if (c >= byte_gap) begin
                // data changes while the clock is high
                dev_data <= frame[k / bit_cycles];
                dev_clk  <= !((ph >= quarter) && (ph < quarter + half_period));
                if (k == 10 * bit_cycles + quarter) begin
                    sent = 1'b1;
                end
            end
        end
        @(posedge clk_sys);
        dev_clk  <= 1'b1;
        dev_data <= 1'b1;
    endtask

    // waits for request-to-send, clocks in 10 bits, then gives the ack bit
    task automatic recv_host(input int limit, output logic [7:0] b, output logic seen,
                             output logic frame_ok);
        logic [9:0] bits;
        int         n;
        int         i;
        seen = 1'b0;
        n    = 0;
        bits = '0;
        while (!seen && n < limit) begin
            @(posedge clk_sys);
            seen = !ps2_clk_oe && ps2_data_oe;
            n++;
        end
        if (seen) begin
            repeat (half_period) @(posedge clk_sys);
            for (i = 0; i < 11; i++) begin
                @(posedge clk_sys);
                dev_clk <= 1'b0;
                if (i == 10) begin
                    dev_data <= 1'b0;
                end
                repeat (half_period) @(posedge clk_sys);
                if (i < 10) begin
                    bits[i] = ps2_data_in;
                end
                dev_clk  <= 1'b1;
                dev_data <= 1'b1;
                repeat (half_period - 1) @(posedge clk_sys);
            end
        end
        b        = bits[7:0];
        frame_ok = (^bits[8:0]) && bits[9];
    endtask

    task automatic expect_cmd(input string name, input logic [7:0] exp, input int limit);
        logic [7:0] b;
        logic       seen;
        logic       frame_ok;
        recv_host(limit, b, seen, frame_ok);
        assert (seen) else begin
            errors++;
            $display("%s: no host command within %0d cycles", name, limit);
        end
        if (seen) begin
            assert (frame_ok) else begin
                errors++;
                $display("%s: host frame has bad parity or a low stop bit", name);
            end
            assert (b == exp) else begin
                errors++;
                $display("Mismatch in %s: expected %h, actual %h", name, exp, b);
            end
        end
    endtask

    task automatic send_checked(input string name, input logic [7:0] b);
        logic sent;
        send_byte(b, 1'b0, sent);
        assert (sent) else begin
            errors++;
            $display("%s: host inhibited the clock during byte %h", name, b);
        end
    endtask

    // device side of the reset and stream enable exchange after 0xFF
    task automatic answer_reset(input string name, input logic ack_enable);
        logic sent;
        int   n;
        send_checked(name, 8'hFA);
        send_checked(name, 8'hAA);
        // device id is normally cut off by the next command
        send_byte(8'h00, 1'b0, sent);
        expect_cmd(name, 8'hF4, 2 * frame_cycles + 4 * inhibit_cycles);
        if (ack_enable) begin
            init_allowed = 1'b1;
            send_checked(name, 8'hFA);
            n = 0;
            while (!init_done && n < 100) begin
                @(posedge clk_sys);
                n++;
            end
            assert (init_done) else begin
                errors++;
                $display("%s: init_done did not rise after the stream enable ack", name);
            end
        end
    endtask

    task automatic check_packet(input string name, input logic [23:0] exp);
        logic [23:0] got;
        int          n;
        n = 0;
        while (pkt_q.size() == 0 && n < 100) begin
            @(posedge clk_sys);
            n++;
        end
        assert (pkt_q.size() == 1) else begin
            errors++;
            $display("%s: expected one packet strobe, saw %0d", name, pkt_q.size());
        end
        if (pkt_q.size() != 0) begin
            got = pkt_q.pop_front();
            assert (got == exp) else begin
                errors++;
                $display("Mismatch in %s: expected %h, actual %h", name, exp, got);
            end
        end
        pkt_q.delete();
    endtask

    // three random bytes with an optional flipped parity byte before the last one
    task automatic send_group(input string name, input logic with_bad);
        logic [7:0] b [3];
        logic       sent;
        int         i;
        for (i = 0; i < 3; i++) begin
            rng_state = xorshift32(rng_state);
            b[i]      = rng_state[7:0];
            if (with_bad && (i == 2)) begin
                // a counted bad byte would complete the packet here
                rng_state = xorshift32(rng_state);
                send_byte(rng_state[7:0], 1'b1, sent);
                assert (pkt_q.size() == 0) else begin
                    errors++;
                    $display("%s: packet strobed after a bad parity byte", name);
                end
            end
            send_checked(name, b[i]);
            if (i < 2) begin
                assert (pkt_q.size() == 0) else begin
                    errors++;
                    $display("%s: packet strobed after only %0d bytes", name, i + 1);
                end
            end
        end
        check_packet(name, {b[2], b[1], b[0]});
    endtask

    initial begin
        int g;
        int n;
        rst_n       <= 1'b0;
        ps2_clk_in  <= 1'b1;
        ps2_data_in <= 1'b1;
        dev_clk     <= 1'b1;
        dev_data    <= 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        assert (!ps2_clk_oe && !ps2_data_oe && !pkt_vld && !init_done
                && (ctrl_state == reset_dev)) else begin
            errors++;
            $display("outputs are not at their reset values during reset");
        end
        @(posedge clk_sys);
        rst_n <= 1'b1;

        expect_cmd("init", 8'hFF, 4 * inhibit_cycles);
        answer_reset("init", 1'b1);

        for (g = 0; g < num_groups; g++) begin
            send_group("packet", 1'b0);
        end
        send_group("bad_frame", 1'b1);

        // silence in stream until the watchdog trips
        n = 0;
        while (init_done && n < (idle_limit_ms + 1) * ms_cycles) begin
            @(posedge clk_sys);
            n++;
        end
        assert (!init_done) else begin
            errors++;
            $display("watchdog: init_done still high after %0d idle cycles", n);
        end
        assert (n >= idle_limit_ms * ms_cycles - 50) else begin
            errors++;
            $display("watchdog: init_done fell after only %0d idle cycles", n);
        end
        init_allowed = 1'b0;
        expect_cmd("watchdog", 8'hFF, 4 * inhibit_cycles);

        // no ack after 0xF4 so the host must start over
        answer_reset("ack_timeout", 1'b0);
        expect_cmd("ack_timeout", 8'hFF, ms_cycles + 4 * inhibit_cycles);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== ps2_mouse_top.sv ====
// PS/2 mouse host top level; ties controller, receiver and transmitter to the open-collector pins
`timescale 1ns/100ps

module ps2_mouse_top
    import ps2_mouse_pkg::*;
#(
    parameter int ms_cycles      = 50_000,
    parameter int idle_limit_ms  = 20_000,
    parameter int inhibit_cycles = 5_000
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        ps2_clk_in,
    input  logic        ps2_data_in,
    output logic        ps2_clk_oe,
    output logic        ps2_data_oe,
    output logic        pkt_vld,
    output logic [23:0] pkt_data,
    output logic        init_done,
    output ctrl_state_t ctrl_state
);

    logic       rd_en;
    logic       rd_vld;
    logic [7:0] rd_data;
    logic       wr_en;
    logic [7:0] wr_data;
    logic       wr_done;
    logic       tx_busy;

    ps2_control #(
        .ms_cycles     (ms_cycles),
        .idle_limit_ms (idle_limit_ms)
    ) u_control (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .rd_vld     (rd_vld),
        .rd_data    (rd_data),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .wr_done    (wr_done),
        .pkt_vld    (pkt_vld),
        .pkt_data   (pkt_data),
        .init_done  (init_done),
        .ctrl_state (ctrl_state)
    );

    ps2_rx u_rx (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ps2_clk_in  (ps2_clk_in),
        .ps2_data_in (ps2_data_in),
        .rd_en       (rd_en),
        .tx_busy     (tx_busy),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

    ps2_tx #(
        .inhibit_cycles (inhibit_cycles)
    ) u_tx (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ps2_clk_in  (ps2_clk_in),
        .ps2_data_in (ps2_data_in),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .ps2_clk_oe  (ps2_clk_oe),
        .ps2_data_oe (ps2_data_oe),
        .tx_busy     (tx_busy),
        .wr_done     (wr_done)
    );

endmodule

// ==== ps2_rx.sv ====
// PS/2 device-to-host receiver; deframes 11-bit frames and strobes each good byte out
`timescale 1ns/100ps

module ps2_rx
    import ps2_mouse_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       ps2_clk_in,
    input  logic       ps2_data_in,
    input  logic       rd_en,
    input  logic       tx_busy,
    output logic       rd_vld,
    output logic [7:0] rd_data
);

    rx_state_t  state;
    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic       data_s;
    logic [2:0] bit_cnt;
    logic [7:0] shift_reg;
    logic       parity_ok;

    // 2-flop synchronizers, idle line is high
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_in};
            data_sync <= {data_sync[0], ps2_data_in};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];
    assign data_s   = data_sync[1];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state     <= rx_idle;
            bit_cnt   <= 3'd0;
            parity_ok <= 1'b0;
            rd_vld    <= 1'b0;
        end else begin
            rd_vld <= 1'b0;
            if (!rd_en || tx_busy) begin
                // host owns the bus or reads are off, drop partial frame
                state   <= rx_idle;
                bit_cnt <= 3'd0;
            end else if (clk_fall) begin
                case (state)
                    rx_idle: begin
                        // start bit is low
                        if (!data_s) begin
                            state   <= rx_shift;
                            bit_cnt <= 3'd0;
                        end
                    end
                    rx_shift: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= rx_parity;
                        end
                    end
                    rx_parity: begin
                        // odd parity over data and parity bit
                        parity_ok <= ^{shift_reg, data_s};
                        state     <= rx_stop;
                    end
                    rx_stop: begin
                        if (data_s && parity_ok) begin
                            rd_vld <= 1'b1;
                        end
                        state <= rx_idle;
                    end
                    default: begin
                        state <= rx_idle;
                    end
                endcase
            end
        end
    end

    // data bits arrive LSB first
    always_ff @(posedge clk_sys) begin
        if (clk_fall && (state == rx_shift)) begin
            shift_reg <= {data_s, shift_reg[7:1]};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (clk_fall && (state == rx_stop) && data_s && parity_ok) begin
            rd_data <= shift_reg;
        end
    end

endmodule

// ==== ps2_tx.sv ====
// PS/2 host-to-device command sender using clock inhibit and request-to-send
`timescale 1ns/100ps

module ps2_tx
    import ps2_mouse_pkg::*;
#(
    parameter int inhibit_cycles = 5_000
) (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       ps2_clk_in,
    input  logic       ps2_data_in,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    output logic       ps2_clk_oe,
    output logic       ps2_data_oe,
    output logic       tx_busy,
    output logic       wr_done
);

    localparam int cnt_w = $clog2(inhibit_cycles + 1);
    localparam logic [cnt_w-1:0] inhibit_last = cnt_w'(inhibit_cycles - 1);

    tx_state_t        state;
    logic [1:0]       clk_sync;
    logic [1:0]       data_sync;
    logic             clk_prev;
    logic             clk_fall;
    logic [cnt_w-1:0] inhibit_cnt;
    logic [3:0]       bit_cnt;
    logic [8:0]       shift_reg;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_in};
            data_sync <= {data_sync[0], ps2_data_in};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state       <= tx_idle;
            inhibit_cnt <= '0;
            bit_cnt     <= 4'd0;
            ps2_clk_oe  <= 1'b0;
            ps2_data_oe <= 1'b0;
        end else begin
            case (state)
                tx_idle: begin
                    if (wr_en) begin
                        // hold clock low to abort any device traffic
                        state       <= tx_inhibit;
                        inhibit_cnt <= '0;
                        ps2_clk_oe  <= 1'b1;
                    end
                end
                tx_inhibit: begin
                    inhibit_cnt <= inhibit_cnt + 1'b1;
                    if (inhibit_cnt == inhibit_last) begin
                        // start bit before the clock is let go
                        ps2_data_oe <= 1'b1;
                        state       <= tx_request;
                    end
                end
                tx_request: begin
                    ps2_clk_oe <= 1'b0;
                    // device now clocks, bit 0 goes out after its first fall
                    if (clk_fall) begin
                        ps2_data_oe <= ~shift_reg[0];
                        bit_cnt     <= 4'd1;
                        state       <= tx_shift;
                    end
                end
                tx_shift: begin
                    if (clk_fall) begin
                        ps2_data_oe <= ~shift_reg[0];
                        bit_cnt     <= bit_cnt + 4'd1;
                        // ninth bit driven is the parity bit
                        if (bit_cnt == 4'd8) begin
                            state <= tx_parity;
                        end
                    end
                end
                tx_parity: begin
                    // release data for the stop bit
                    if (clk_fall) begin
                        ps2_data_oe <= 1'b0;
                        state       <= tx_stop;
                    end
                end
                tx_stop: begin
                    // device ack clock
                    if (clk_fall) begin
                        state <= tx_ack;
                    end
                end
                tx_ack: begin
                    // wait for the device to release both lines
                    if (clk_sync[1] && data_sync[1]) begin
                        state <= tx_done;
                    end
                end
                tx_done: begin
                    state <= tx_idle;
                end
                default: begin
                    state       <= tx_idle;
                    ps2_clk_oe  <= 1'b0;
                    ps2_data_oe <= 1'b0;
                end
            endcase
        end
    end

    // byte plus odd parity, shifted out LSB first
    always_ff @(posedge clk_sys) begin
        if ((state == tx_idle) && wr_en) begin
            shift_reg <= {~^wr_data, wr_data};
        end else if (clk_fall && ((state == tx_request) || (state == tx_shift))) begin
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

    assign tx_busy = (state != tx_idle);
    assign wr_done = (state == tx_done);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module ps2_mouse_tb -f ps2_mouse.f -o ps2_mouse_sim

./obj_dir/ps2_mouse_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "result: FAIL"
    exit 1
fi
echo "result: PASS"
